// ==== build.f ====
src/barrett_pkg.sv
src/pipe_multiplier.sv
src/quotient_estimator.sv
src/operand_delay.sv
src/reduce_finalize.sv
src/barrett_reduce_top.sv
test/barrett_reduce_assert.sv
test/barrett_reduce_tb.sv

// ==== src/barrett_pkg.sv ====
`default_nettype none

package barrett_pkg;

  // Operand word width.
  localparam int unsigned DATA_LENGTH = 32;

  // Register stages in each multiplier.
  localparam int unsigned NUM_MULS = 3;

  // Two multipliers plus the quotient register.
  localparam int unsigned EST_LATENCY = 2 * NUM_MULS + 1;

  // Estimator plus the finalize register.
  localparam int unsigned TOTAL_LATENCY = EST_LATENCY + 1;

  typedef logic [DATA_LENGTH-1:0]   data_t;
  typedef logic [2*DATA_LENGTH-1:0] prod_t;

endpackage : barrett_pkg

`default_nettype wire

// ==== src/barrett_reduce_top.sv ====
`timescale 1ns/100ps
`default_nettype none

module barrett_reduce_top (
  input  wire logic               clk_i,
  input  wire logic               rst_ni,
  input  wire logic               start_i,
  input  wire barrett_pkg::data_t x_i,
  input  wire barrett_pkg::data_t m_i,
  input  wire barrett_pkg::data_t m_bl_i,
  input  wire barrett_pkg::data_t mu_i,
  output logic                    valid_o,
  output barrett_pkg::data_t      result_o
);
  import barrett_pkg::*;

  prod_t qm;
  logic  qm_valid; // Checked against valid_dly by the bound assertions.
  data_t x_dly;
  data_t m_dly;
  logic  bypass;
  logic  valid_dly;

  quotient_estimator quotient_estimator_i (
    .clk_i      (clk_i),
    .rst_ni     (rst_ni),
    .start_i    (start_i),
    .x_i        (x_i),
    .mu_i       (mu_i),
    .m_bl_i     (m_bl_i),
    .m_i        (m_i),
    .qm_valid_o (qm_valid),
    .qm_o       (qm)
  );

  operand_delay operand_delay_i (
    .clk_i       (clk_i),
    .rst_ni      (rst_ni),
    .start_i     (start_i),
    .x_i         (x_i),
    .m_i         (m_i),
    .valid_dly_o (valid_dly),
    .bypass_o    (bypass),
    .x_dly_o     (x_dly),
    .m_dly_o     (m_dly)
  );

  reduce_finalize reduce_finalize_i (
    .clk_i    (clk_i),
    .rst_ni   (rst_ni),
    .valid_i  (valid_dly),
    .bypass_i (bypass),
    .x_i      (x_dly),
    .m_i      (m_dly),
    .qm_i     (qm),
    .valid_o  (valid_o),
    .result_o (result_o)
  );

endmodule : barrett_reduce_top

`default_nettype wire

// ==== src/operand_delay.sv ====
`timescale 1ns/100ps
`default_nettype none

module operand_delay (
  input  wire logic               clk_i,
  input  wire logic               rst_ni,
  input  wire logic               start_i,
  input  wire barrett_pkg::data_t x_i,
  input  wire barrett_pkg::data_t m_i,
  output logic                    valid_dly_o,
  output logic                    bypass_o,
  output barrett_pkg::data_t      x_dly_o,
  output barrett_pkg::data_t      m_dly_o
);
  import barrett_pkg::*;

  data_t                  x_pipe [EST_LATENCY];
  data_t                  m_pipe [EST_LATENCY];
  logic [EST_LATENCY-1:0] bypass_pipe;
  logic [EST_LATENCY-1:0] valid_pipe;

  always_ff @(posedge clk_i) begin
    x_pipe[0] <= x_i;
    m_pipe[0] <= m_i;
    for (int i = 1; i < EST_LATENCY; i++) begin
      x_pipe[i] <= x_pipe[i-1];
      m_pipe[i] <= m_pipe[i-1];
    end
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      bypass_pipe <= '0;
      valid_pipe  <= '0;
    end else begin
      bypass_pipe <= {bypass_pipe[EST_LATENCY-2:0], x_i < m_i}; // Already reduced.
      valid_pipe  <= {valid_pipe[EST_LATENCY-2:0], start_i};
    end
  end

  assign x_dly_o     = x_pipe[EST_LATENCY-1];
  assign m_dly_o     = m_pipe[EST_LATENCY-1];
  assign bypass_o    = bypass_pipe[EST_LATENCY-1];
  assign valid_dly_o = valid_pipe[EST_LATENCY-1];

endmodule : operand_delay

`default_nettype wire

// ==== src/pipe_multiplier.sv ====
`timescale 1ns/100ps
`default_nettype none

module pipe_multiplier (
  input  wire logic               clk_i,
  input  wire logic               rst_ni,
  input  wire logic               valid_i,
  input  wire barrett_pkg::data_t a_i,
  input  wire barrett_pkg::data_t b_i,
  output logic                    valid_o,
  output barrett_pkg::prod_t      product_o
);
  import barrett_pkg::*;

  prod_t               prod_q [NUM_MULS];
  logic [NUM_MULS-1:0] valid_q;

  // Product is formed in the first stage and then only delayed,
  // leaving room for retiming across the later stages.
  always_ff @(posedge clk_i) begin
    prod_q[0] <= a_i * b_i;
    for (int i = 1; i < NUM_MULS; i++) begin
      prod_q[i] <= prod_q[i-1];
    end
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      valid_q <= '0;
    end else begin
      valid_q <= {valid_q[NUM_MULS-2:0], valid_i}; // Travels beside the product.
    end
  end

  assign product_o = prod_q[NUM_MULS-1];
  assign valid_o   = valid_q[NUM_MULS-1];

endmodule : pipe_multiplier

`default_nettype wire

// ==== src/quotient_estimator.sv ====
`timescale 1ns/100ps
`default_nettype none

module quotient_estimator (
  input  wire logic               clk_i,
  input  wire logic               rst_ni,
  input  wire logic               start_i,
  input  wire barrett_pkg::data_t x_i,
  input  wire barrett_pkg::data_t mu_i,
  input  wire barrett_pkg::data_t m_bl_i,
  input  wire barrett_pkg::data_t m_i,
  output logic                    qm_valid_o,
  output barrett_pkg::prod_t      qm_o
);
  import barrett_pkg::*;

  data_t m_pipe [NUM_MULS];
  data_t k_pipe [NUM_MULS];
  logic  xmu_valid;
  prod_t xmu_prod;
  prod_t xmu_shifted;
  logic  q_valid;
  data_t q;
  data_t q_m;

  pipe_multiplier mul_xmu (
    .clk_i     (clk_i),
    .rst_ni    (rst_ni),
    .valid_i   (start_i),
    .a_i       (x_i),
    .b_i       (mu_i),
    .valid_o   (xmu_valid),
    .product_o (xmu_prod)
  );

  // Keep m and k in step with the first product.
  always_ff @(posedge clk_i) begin
    m_pipe[0] <= m_i;
    k_pipe[0] <= m_bl_i;
    for (int i = 1; i < NUM_MULS; i++) begin
      m_pipe[i] <= m_pipe[i-1];
      k_pipe[i] <= k_pipe[i-1];
    end
  end

  assign xmu_shifted = xmu_prod >> {k_pipe[NUM_MULS-1], 1'b0}; // Divide by 4^k.

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      q_valid <= 1'b0;
    end else begin
      q_valid <= xmu_valid;
    end
  end

  always_ff @(posedge clk_i) begin
    q   <= xmu_shifted[DATA_LENGTH-1:0]; // Fits since x < 4^k.
    q_m <= m_pipe[NUM_MULS-1];
  end

  pipe_multiplier mul_qm (
    .clk_i     (clk_i),
    .rst_ni    (rst_ni),
    .valid_i   (q_valid),
    .a_i       (q),
    .b_i       (q_m),
    .valid_o   (qm_valid_o),
    .product_o (qm_o)
  );

endmodule : quotient_estimator

`default_nettype wire

// ==== src/reduce_finalize.sv ====
`timescale 1ns/100ps
`default_nettype none

module reduce_finalize (
  input  wire logic               clk_i,
  input  wire logic               rst_ni,
  input  wire logic               valid_i,
  input  wire logic               bypass_i,
  input  wire barrett_pkg::data_t x_i,
  input  wire barrett_pkg::data_t m_i,
  input  wire barrett_pkg::prod_t qm_i,
  output logic                    valid_o,
  output barrett_pkg::data_t      result_o
);
  import barrett_pkg::*;

  data_t diff;
  data_t corr_1;
  data_t corr_2;
  data_t result_d;

  // The estimate is at most two short, so the remainder is below 3m.
  always_comb begin
    diff     = x_i - qm_i[DATA_LENGTH-1:0]; // q*m never exceeds x.
    corr_1   = (diff >= m_i) ? diff - m_i : diff;
    corr_2   = (corr_1 >= m_i) ? corr_1 - m_i : corr_1;
    result_d = bypass_i ? x_i : corr_2;
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      valid_o  <= 1'b0;
      result_o <= '0;
    end else begin
      valid_o <= valid_i;
      if (valid_i) begin
        result_o <= result_d; // Holds between items.
      end
    end
  end

endmodule : reduce_finalize

`default_nettype wire

// ==== test/barrett_reduce_assert.sv ====
`timescale 1ns/100ps
`default_nettype none

module barrett_reduce_assert (
  input wire logic               clk_i,
  input wire logic               rst_ni,
  input wire logic               start_i,
  input wire barrett_pkg::data_t m_i,
  input wire logic               qm_valid_i,
  input wire logic               valid_dly_i,
  input wire logic               valid_i,
  input wire barrett_pkg::data_t result_i
);
  import barrett_pkg::*;

  int unsigned error_count = 0; // Failed assertions so far.

  valid_latency_a: assert property (@(posedge clk_i) disable iff (!rst_ni)
    valid_i == $past(start_i, TOTAL_LATENCY))
    else begin
      $error("valid_o is not start_i delayed by %0d cycles", TOTAL_LATENCY);
      error_count++;
    end

  // Modulus of the item that is leaving now.
  result_range_a: assert property (@(posedge clk_i) disable iff (!rst_ni)
    valid_i |-> result_i < $past(m_i, TOTAL_LATENCY))
    else begin
      $error("result_o is not below the modulus of its item");
      error_count++;
    end

  side_valid_a: assert property (@(posedge clk_i) disable iff (!rst_ni)
    qm_valid_i == valid_dly_i)
    else begin
      $error("Estimator valid and delay line valid disagree");
      error_count++;
    end

  reset_valid_a: assert property (@(posedge clk_i) !rst_ni |-> !valid_i)
    else begin
      $error("valid_o is high while reset is active");
      error_count++;
    end

endmodule : barrett_reduce_assert

bind barrett_reduce_top barrett_reduce_assert barrett_reduce_assert_i (
  .clk_i       (clk_i),
  .rst_ni      (rst_ni),
  .start_i     (start_i),
  .m_i         (m_i),
  .qm_valid_i  (qm_valid),
  .valid_dly_i (valid_dly),
  .valid_i     (valid_o),
  .result_i    (result_o)
);

`default_nettype wire

// ==== test/barrett_reduce_tb.sv ====
`timescale 1ns/100ps
`default_nettype none

module barrett_reduce_tb;
  import barrett_pkg::*;

  localparam int unsigned NUM_ITEMS      = 40;
  localparam int unsigned NUM_FIELDS     = 5; // x, m, k, mu, remainder.
  localparam int unsigned RESET_CYCLES   = 5;
  localparam int unsigned IDLE_CYCLES    = 3;
  localparam int unsigned MAX_GAP        = 3;
  localparam int unsigned TIMEOUT_CYCLES = NUM_ITEMS * 4 + TOTAL_LATENCY + 20;
  localparam int unsigned LCG_SEED       = 36;
  localparam int unsigned LCG_MUL        = 32'd1103515245;
  localparam int unsigned LCG_INC        = 32'd12345;

  logic  clk = 1'b0;
  logic  rst_n;
  logic  start;
  data_t x;
  data_t m;
  data_t m_bl;
  data_t mu;
  logic  valid;
  data_t result;

  data_t       test_vec [NUM_ITEMS*NUM_FIELDS];
  data_t       exp_result_q [$];
  int unsigned exp_cycle_q [$];
  int unsigned exp_item_q [$];
  int unsigned cycle_count   = 0;
  int unsigned checked_count = 0;
  int unsigned lcg_state     = LCG_SEED;

  barrett_reduce_top barrett_reduce_top_i (
    .clk_i    (clk),
    .rst_ni   (rst_n),
    .start_i  (start),
    .x_i      (x),
    .m_i      (m),
    .m_bl_i   (m_bl),
    .mu_i     (mu),
    .valid_o  (valid),
    .result_o (result)
  );

  always #5 clk = ~clk;

  task automatic fail_run(input string msg);
    $display("%s", msg);
    $display("SIMULATION FAILED");
    $fatal(1);
  endtask

  task automatic check_result(input data_t got, input data_t exp, input string what);
    if (got !== exp) begin
      fail_run($sformatf("MISMATCH at %0t: %s result %h, expected %h", $time, what, got, exp));
    end
  endtask

  task automatic check_valid_cycle(input int unsigned got, input int unsigned exp,
                                   input int unsigned item);
    if (got != exp) begin
      fail_run($sformatf("MISMATCH at %0t: item %0d valid in cycle %0d, expected cycle %0d",
                         $time, item, got, exp));
    end
  endtask

  function automatic int unsigned lcg_next(input int unsigned state);
    return state * LCG_MUL + LCG_INC;
  endfunction

  function automatic int unsigned gap_from_random(input int unsigned value);
    int unsigned pick;
    pick = (value >> 16) % 8;
    return (pick <= 7 - MAX_GAP) ? 0 : pick - (7 - MAX_GAP); // Mostly back-to-back.
  endfunction

  task automatic idle_cycle();
    start = 1'b0;
    @(posedge clk);
    #1;
  endtask

  task automatic drive_item(input int unsigned idx);
    int unsigned base;
    base  = idx * NUM_FIELDS;
    start = 1'b1;
    x     = test_vec[base];
    m     = test_vec[base+1];
    m_bl  = test_vec[base+2];
    mu    = test_vec[base+3];
    exp_result_q.push_back(test_vec[base+4]);
    exp_cycle_q.push_back(cycle_count + TOTAL_LATENCY);
    exp_item_q.push_back(idx);
    @(posedge clk);
    #1;
  endtask

  always @(posedge clk) begin
    cycle_count <= cycle_count + 1;
    if (cycle_count >= TIMEOUT_CYCLES) begin
      fail_run("Timeout before all items came out of the DUT");
    end
  end

  // Mid-cycle sampling, away from the clock edge.
  always @(negedge clk) begin
    data_t       exp_result;
    int unsigned exp_cycle;
    int unsigned item;
    if (barrett_reduce_top_i.barrett_reduce_assert_i.error_count != 0) begin
      fail_run("A bound assertion failed during the run");
    end else if (valid) begin
      if (exp_result_q.size() == 0) begin
        fail_run($sformatf("Unexpected valid_o at %0t with no item in flight", $time));
      end else begin
        exp_result = exp_result_q.pop_front();
        exp_cycle  = exp_cycle_q.pop_front();
        item       = exp_item_q.pop_front();
        check_valid_cycle(cycle_count, exp_cycle, item);
        check_result(result, exp_result, $sformatf("item %0d", item));
        checked_count++;
      end
    end else if (exp_cycle_q.size() != 0 && cycle_count > exp_cycle_q[0]) begin
      fail_run($sformatf("valid_o never came for item %0d, seen at %0t", exp_item_q[0], $time));
    end
  end

  initial begin
    int unsigned gap;
    rst_n = 1'b0;
    start = 1'b0;
    x     = '0;
    m     = '0;
    m_bl  = '0;
    mu    = '0;
    $readmemh("test/barrett_testdata.txt", test_vec);
    if ($isunknown(test_vec[NUM_ITEMS*NUM_FIELDS-1])) begin
      fail_run("Test data file is missing or holds too few items");
    end
    repeat (RESET_CYCLES) @(posedge clk);
    #1;
    rst_n = 1'b1;
    check_result(result, '0, "reset");
    repeat (IDLE_CYCLES) idle_cycle(); // Quiet outputs with no start.
    for (int i = 0; i < NUM_ITEMS; i++) begin
      lcg_state = lcg_next(lcg_state);
      gap       = gap_from_random(lcg_state);
      repeat (gap) idle_cycle();
      drive_item(i);
    end
    start = 1'b0;
    while (checked_count < NUM_ITEMS) begin
      @(posedge clk);
    end
    repeat (TOTAL_LATENCY) @(posedge clk); // Stray valids show up here.
    if (barrett_reduce_top_i.barrett_reduce_assert_i.error_count != 0) begin
      fail_run("Bound assertions reported errors during the run");
    end else begin
      $display("SIMULATION PASSED");
      $finish;
    end
  end

endmodule : barrett_reduce_tb

`default_nettype wire

// ==== test/barrett_testdata.txt ====
// One item per line in hex
// x        m        k        mu       x mod m
00000008 00000003 00000002 00000005 00000002
00000003 00000002 00000002 00000008 00000001
00000002 00000003 00000002 00000005 00000002
00000018 00000005 00000003 0000000C 00000004
00000014 00000005 00000003 0000000C 00000000
00000030 00000007 00000003 00000009 00000006
0000000F 00000004 00000003 00000010 00000003
00000078 0000000B 00000004 00000017 0000000A
0000000D 0000000D 00000004 00000013 00000000
0000000E 0000000D 00000004 00000013 00000001
000000E0 0000000F 00000004 00000011 0000000E
00000120 00000011 00000005 0000003C 00000010
000003C0 0000001F 00000005 00000021 0000001E
00000005 0000001F 00000005 00000021 00000005
000003E8 00000025 00000006 0000006E 00000001
00000F80 0000003F 00000006 00000041 0000003E
0000270F 00000064 00000007 000000A3 00000063
000018CE 0000007F 00000007 00000081 00000000
00009C3F 000000C8 00000008 00000147 000000C7
00000100 000000FF 00000008 00000101 00000001
00010000 00000101 00000009 000003FC 00000001
0001E240 000001F4 00000009 0000020C 000001C8
000F423F 000003E8 0000000A 00000418 000003E7
00000007 000003E8 0000000A 00000418 00000007
003FF000 000007FF 0000000B 00000801 000007FE
00100400 00000401 0000000B 00000FFC 00000000
0089543F 00000BB8 0000000C 000015D8 00000BB7
00400000 00000801 0000000C 00001FFC 00000001
01001000 00001001 0000000D 00003FFC 00000000
03FFC000 00001FFF 0000000D 00002001 00001FFE
05F5E0FF 00002710 0000000E 000068DB 0000270F
075BCD15 00003039 0000000E 000054F0 00001A85
35A4E8FF 00007530 0000000F 00008BCF 0000752F
10004000 00004001 0000000F 0000FFFC 00000000
FFFE0000 0000FFFF 00000010 00010001 0000FFFE
EE6B2800 0000FFF1 00000010 0001000F 00002117
3FFFFFFF 00008000 00000010 00020000 00007FFF
499602D2 00009C40 00000010 0001A36E 00001ED2
00009C3F 00009C40 00000010 0001A36E 00009C3F
00015E64 0000012C 00000009 00000369 00000000
